// ==== Makefile ====
SIM = obj_dir/VdatapathTop_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f datapathTop.f --top-module datapathTop_tb

run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir

// ==== datapathTop.f ====
verilog/cpuPkg.sv
verilog/controlSequencer.sv
verilog/registerSelect.sv
verilog/generalRegister.sv
verilog/busMultiplexer.sv
verilog/aluUnit.sv
verilog/datapathTop.sv
verif/datapathTop_checker.sv
verif/resultMonitor.sv
verif/datapathTop_tb.sv

// ==== verif/datapathTop_checker.sv ====
`timescale 1ns/1ps

module datapathTop_checker (
    input logic       Clock,
    input logic       arstN,
    input logic       instrValid,
    input logic       instrReady,
    input logic [4:0] instrOp,
    input logic       wbValid,
    input logic       baseOut,
    input logic       rcOut,
    input logic       constOut,
    input logic       zOut
);

    // busy through tY, tZ and tWrite, then ready again
    readyOnlyInIdle: assert property (@(posedge Clock) disable iff (!arstN)
        (instrValid && instrReady && instrOp <= 5'd7) |=>
            !instrReady ##1 !instrReady ##1 !instrReady ##1 instrReady)
        else $error("instrReady high while an instruction is executing");

    illegalBackToIdle: assert property (@(posedge Clock) disable iff (!arstN)
        (instrValid && instrReady && instrOp > 5'd7) |=> !instrReady ##1 instrReady)
        else $error("illegal opcode did not return to idle on the next edge");

    // legal ops write back three cycles after acceptance
    writeBackTiming: assert property (@(posedge Clock) disable iff (!arstN)
        (instrValid && instrReady && instrOp <= 5'd7) |-> ##3 wbValid)
        else $error("wbValid missing three cycles after acceptance");

    singleBusSource: assert property (@(posedge Clock) disable iff (!arstN)
        $onehot0({baseOut, rcOut, constOut, zOut}))
        else $error("more than one bus source active");

endmodule

bind controlSequencer datapathTop_checker CHK (
    .Clock      (Clock),
    .arstN      (arstN),
    .instrValid (instrValid),
    .instrReady (instrReady),
    .instrOp    (instrWord.rFormat.op),
    .wbValid    (wbValid),
    .baseOut    (baseOut),
    .rcOut      (rcOut),
    .constOut   (constOut),
    .zOut       (zOut)
);

// ==== verif/datapathTop_tb.sv ====
`timescale 1ns/1ps

module datapathTop_tb;

    localparam int waitLimit = 50;

    logic        Clock;
    logic        arstN;
    logic        instrValid;
    logic        instrReady;
    logic [31:0] instrWord;
    logic        wbValid;
    logic [3:0]  wbReg;
    logic [31:0] wbData;
    logic [31:0] lcgState;
    int          tbErrors;

    datapathTop DUT (
        .Clock      (Clock),
        .arstN      (arstN),
        .instrValid (instrValid),
        .instrReady (instrReady),
        .instrWord  (instrWord),
        .wbValid    (wbValid),
        .wbReg      (wbReg),
        .wbData     (wbData)
    );

    resultMonitor MON (
        .Clock      (Clock),
        .arstN      (arstN),
        .instrValid (instrValid),
        .instrReady (instrReady),
        .instrWord  (instrWord),
        .wbValid    (wbValid),
        .wbReg      (wbReg),
        .wbData     (wbData)
    );

    initial begin
        Clock = 1'b0;
        forever #4 Clock = ~Clock;
    end

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // expected result from the operation rules
    function automatic logic [31:0] refResult(input logic [4:0] op, input logic [31:0] a,
                                              input logic [31:0] b);
        case (op)
            5'd0, 5'd7: return a + b;
            5'd1: return a - b;
            5'd2: return a & b;
            5'd3: return a | b;
            5'd4: return a >> b[4:0];
            5'd5: return $unsigned($signed(a) >>> b[4:0]);
            5'd6: return a << b[4:0];
            default: return 32'h0;
        endcase
    endfunction

    // called on a falling edge, returns on the falling edge after acceptance
    task automatic issue(input logic [4:0] op, input logic [3:0] ra, input logic [3:0] rb,
                         input logic [18:0] tail);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] expected;
        int          waited;
        instrWord = {op, ra, rb, tail};
        instrValid = 1'b1;
        waited = 0;
        while (!instrReady && waited < waitLimit) begin
            @(negedge Clock);
            waited++;
        end
        if (!instrReady) begin
            $display("timed out waiting for instrReady");
            tbErrors++;
            instrValid = 1'b0;
        end else begin
            if (op <= 5'd7) begin
                // model is current here, the previous write-back has landed
                a = (rb == 4'd0) ? 32'h0 : MON.modelRegs[rb];
                b = (op == 5'd7) ? {{13{tail[18]}}, tail} : MON.modelRegs[tail[18:15]];
                expected = refResult(op, a, b);
                MON.addExpected(ra, expected);
            end
            @(negedge Clock);
        end
    endtask

    task automatic regOp(input logic [4:0] op, input logic [3:0] ra, input logic [3:0] rb,
                         input logic [3:0] rc);
        issue(op, ra, rb, {rc, 15'h0});
    endtask

    task automatic loadImm(input logic [3:0] ra, input logic [18:0] imm);
        issue(5'd7, ra, 4'd0, imm);
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        instrValid = 1'b0;
        while ((MON.pending != 0 || !instrReady) && waited < waitLimit) begin
            @(negedge Clock);
            waited++;
        end
        if (MON.pending != 0 || !instrReady) begin
            $display("timed out waiting for outstanding write-backs");
            tbErrors++;
        end
    endtask

    initial begin
        logic [31:0] rnd;
        lcgState = 32'h91ef_4b45;
        arstN = 1'b0;
        instrValid = 1'b0;
        instrWord = 32'h0;
        tbErrors = 0;
        repeat (2) @(posedge Clock);
        @(negedge Clock);
        arstN = 1'b1;
        @(negedge Clock);

        for (int r = 0; r < 16; r++) begin
            rnd = nextRandom();
            loadImm(r[3:0], rnd[18:0]);
        end
        regOp(5'd0, 4'd5, 4'd0, 4'd3);  // R0 as base still reads zero
        drain();

        loadImm(4'd1, 19'h7ffff);
        loadImm(4'd2, 19'h00001);
        regOp(5'd0, 4'd3, 4'd1, 4'd2);  // wraps to zero
        regOp(5'd1, 4'd4, 4'd0, 4'd2);
        for (int n = 0; n < 40; n++) begin
            rnd = nextRandom();
            regOp({3'b0, rnd[1:0]}, rnd[7:4], rnd[11:8], rnd[15:12]);
        end
        drain();

        loadImm(4'd3, 19'h7fffb);  // negative operand for shra
        loadImm(4'd5, 19'd0);
        regOp(5'd4, 4'd1, 4'd3, 4'd5);
        regOp(5'd5, 4'd2, 4'd3, 4'd5);
        regOp(5'd6, 4'd4, 4'd3, 4'd5);
        loadImm(4'd5, 19'd31);
        regOp(5'd4, 4'd1, 4'd3, 4'd5);
        regOp(5'd5, 4'd2, 4'd3, 4'd5);
        regOp(5'd6, 4'd4, 4'd3, 4'd5);
        for (int n = 0; n < 30; n++) begin
            rnd = nextRandom();
            regOp((rnd[1:0] == 2'd3) ? 5'd6 : 5'd4 + {3'b0, rnd[1:0]},
                  rnd[7:4], rnd[11:8], rnd[15:12]);
        end
        drain();

        for (int n = 0; n < 10; n++) begin
            rnd = nextRandom();
            issue(rnd[4:0] | 5'b01000, rnd[8:5], rnd[12:9], rnd[31:13]);
        end
        for (int r = 0; r < 16; r++) begin
            regOp(5'd0, r[3:0], 4'd0, r[3:0]);  // read back unchanged
        end
        drain();

        regOp(5'd0, 4'd2, 4'd1, 4'd3);
        instrValid = 1'b0;
        arstN = 1'b0;
        #1;
        if (instrReady !== 1'b1) begin
            $display("mismatch instrReady: got %h expected %h", instrReady, 1'b1);
            tbErrors++;
        end
        if (wbValid !== 1'b0) begin
            $display("mismatch wbValid: got %h expected %h", wbValid, 1'b0);
            tbErrors++;
        end
        @(negedge Clock);
        arstN = 1'b1;
        @(negedge Clock);
        for (int r = 0; r < 16; r++) begin
            regOp(5'd0, r[3:0], 4'd0, r[3:0]);
        end
        drain();

        $display("errors: stimulus %0d, monitor %0d", tbErrors, MON.errorCount);
        if (tbErrors == 0 && MON.errorCount == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== verif/resultMonitor.sv ====
`timescale 1ns/1ps

module resultMonitor (
    input logic        Clock,
    input logic        arstN,
    input logic        instrValid,
    input logic        instrReady,
    input logic [31:0] instrWord,
    input logic        wbValid,
    input logic [3:0]  wbReg,
    input logic [31:0] wbData
);

    logic [3:0]  expReg[$];
    logic [31:0] expData[$];
    int unsigned dueCycle[$];
    int unsigned cycle;
    logic [31:0] modelRegs[16];  // register contents as seen through write-back
    int          errorCount = 0;
    int          pending = 0;

    task automatic addExpected(input logic [3:0] ra, input logic [31:0] value);
        expReg.push_back(ra);
        expData.push_back(value);
        pending = expReg.size();
    endtask

    always @(posedge Clock or negedge arstN) begin
        logic [3:0]  eReg;
        logic [31:0] eData;
        int unsigned due;
        if (!arstN) begin
            expReg.delete();
            expData.delete();
            dueCycle.delete();
            pending = 0;
            cycle = 0;
            for (int i = 0; i < 16; i++) begin
                modelRegs[i] = 32'h0;
            end
        end else begin
            cycle = cycle + 1;
            if (wbValid) begin
                if (expReg.size() == 0 || dueCycle.size() == 0) begin
                    $display("unexpected write-back to register %0d", wbReg);
                    errorCount++;
                end else begin
                    eReg = expReg.pop_front();
                    eData = expData.pop_front();
                    due = dueCycle.pop_front();
                    pending = expReg.size();
                    if (wbReg !== eReg) begin
                        $display("mismatch wbReg: got %h expected %h", wbReg, eReg);
                        errorCount++;
                    end
                    if (wbData !== eData) begin
                        $display("mismatch wbData: got %h expected %h", wbData, eData);
                        errorCount++;
                    end
                    if (cycle != due) begin
                        $display("write-back came at cycle %0d instead of cycle %0d", cycle, due);
                        errorCount++;
                    end
                    modelRegs[eReg] = eData;
                end
            end
            if (instrValid && instrReady && instrWord[31:27] <= 5'd7) begin
                dueCycle.push_back(cycle + 3);  // legal ops only
            end
        end
    end

endmodule

// ==== verilog/aluUnit.sv ====
`timescale 1ns/1ps

module aluUnit (
    input  logic                       Clock,
    input  logic                       arstN,
    input  logic [31:0]                busValue,
    input  logic                       yLoad,
    input  logic                       zLoad,
    input  logic [cpuPkg::opWidth-1:0] aluOp,
    output logic [31:0]                zValue
);

    logic [31:0] yValue;
    logic [31:0] result;
    logic [4:0]  shiftAmount;

    assign shiftAmount = busValue[4:0];  // only the low 5 bits count

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            yValue <= '0;
        end else if (yLoad) begin
            yValue <= busValue;
        end
    end

    always_comb begin
        case (aluOp)
            cpuPkg::opAdd,
            cpuPkg::opAddi: result = yValue + busValue;  // wraps at 32 bits
            cpuPkg::opSub:  result = yValue - busValue;
            cpuPkg::opAnd:  result = yValue & busValue;
            cpuPkg::opOr:   result = yValue | busValue;
            cpuPkg::opShr:  result = yValue >> shiftAmount;
            cpuPkg::opShra: result = $unsigned($signed(yValue) >>> shiftAmount);
            cpuPkg::opShl:  result = yValue << shiftAmount;
            default:        result = '0;
        endcase
    end

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            zValue <= '0;
        end else if (zLoad) begin
            zValue <= result;
        end
    end

endmodule

// ==== verilog/busMultiplexer.sv ====
`timescale 1ns/1ps

module busMultiplexer (
    input  logic [15:0][31:0] regValues,
    input  logic [15:0]       driveEn,
    input  logic              baseZero,
    input  logic              constOut,
    input  logic [31:0]       constant,
    input  logic              zOut,
    input  logic [31:0]       zValue,
    output logic [31:0]       busValue
);

    logic [31:0] regSource;

    // and-or select, at most one drive bit is set at a time
    always_comb begin
        regSource = '0;
        for (int i = 0; i < 16; i++) begin
            if (driveEn[i]) begin
                regSource = regSource | regValues[i];
            end
        end
    end

    always_comb begin
        busValue = regSource;
        if (constOut) begin
            busValue = busValue | constant;
        end
        if (zOut) begin
            busValue = busValue | zValue;
        end
        if (baseZero) begin
            busValue = '0;  // R0 in base position
        end
    end

endmodule

// ==== verilog/controlSequencer.sv ====
`timescale 1ns/1ps

module controlSequencer (
    input  logic                             Clock,
    input  logic                             arstN,
    input  logic                             instrValid,
    input  cpuPkg::instrFields               instrWord,
    output logic                             instrReady,
    output logic [cpuPkg::regIndexWidth-1:0] selRa,
    output logic [cpuPkg::regIndexWidth-1:0] selRb,
    output logic [cpuPkg::regIndexWidth-1:0] selRc,
    output logic [31:0]                      constant,
    output logic                             regIn,
    output logic                             baseOut,
    output logic                             rcOut,
    output logic                             constOut,
    output logic                             zOut,
    output logic                             yLoad,
    output logic                             zLoad,
    output logic [cpuPkg::opWidth-1:0]       aluOp,
    output logic                             wbValid,
    output logic [cpuPkg::regIndexWidth-1:0] wbReg
);

    localparam logic [1:0] idle   = 2'd0;
    localparam logic [1:0] tY     = 2'd1;  // rb into Y
    localparam logic [1:0] tZ     = 2'd2;  // Y op second operand into Z
    localparam logic [1:0] tWrite = 2'd3;  // Z back to ra

    logic [1:0]         state;
    logic [1:0]         nextState;
    cpuPkg::instrFields instrReg;
    logic               accept;
    logic               legal;
    logic               isImm;

    assign instrReady = (state == idle);
    assign accept     = instrValid && instrReady;

    assign legal = (instrReg.rFormat.op <= cpuPkg::opAddi);
    assign isImm = (instrReg.rFormat.op == cpuPkg::opAddi);

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            state    <= idle;
            instrReg <= '0;
        end else begin
            state <= nextState;
            if (accept) begin
                instrReg <= instrWord;
            end
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            idle:    nextState = accept ? tY : idle;
            tY:      nextState = legal ? tZ : idle;  // illegal op drops out here
            tZ:      nextState = tWrite;
            tWrite:  nextState = idle;
            default: nextState = idle;
        endcase
    end

    always_comb begin
        baseOut  = 1'b0;
        yLoad    = 1'b0;
        rcOut    = 1'b0;
        constOut = 1'b0;
        zLoad    = 1'b0;
        zOut     = 1'b0;
        regIn    = 1'b0;
        case (state)
            tY: begin
                baseOut = legal;
                yLoad   = legal;
            end
            tZ: begin
                rcOut    = !isImm;
                constOut = isImm;
                zLoad    = 1'b1;
            end
            tWrite: begin
                zOut  = 1'b1;
                regIn = 1'b1;
            end
            default: ;
        endcase
    end

    assign selRa = instrReg.rFormat.ra;
    assign selRb = instrReg.rFormat.rb;
    assign selRc = instrReg.rFormat.rc;

    assign constant = {{(32 - cpuPkg::constWidth){instrReg.iFormat.imm[cpuPkg::constWidth-1]}},
                       instrReg.iFormat.imm};

    assign aluOp   = instrReg.rFormat.op;
    assign wbValid = regIn;  // write-back shows the same cycle ra loads
    assign wbReg   = selRa;

endmodule

// ==== verilog/cpuPkg.sv ====
package cpuPkg;

    localparam int opWidth = 5;
    localparam int regIndexWidth = 4;
    localparam int constWidth = 19;

    // opcode values, anything above opAddi is illegal
    localparam logic [opWidth-1:0] opAdd  = 5'd0;
    localparam logic [opWidth-1:0] opSub  = 5'd1;
    localparam logic [opWidth-1:0] opAnd  = 5'd2;
    localparam logic [opWidth-1:0] opOr   = 5'd3;
    localparam logic [opWidth-1:0] opShr  = 5'd4;  // logical, zero fill
    localparam logic [opWidth-1:0] opShra = 5'd5;  // arithmetic, sign fill
    localparam logic [opWidth-1:0] opShl  = 5'd6;
    localparam logic [opWidth-1:0] opAddi = 5'd7;  // rb = R0 gives a constant load

    // one instruction word, read either as three registers or as two plus a constant
    typedef union packed {
        struct packed {
            logic [opWidth-1:0]       op;
            logic [regIndexWidth-1:0] ra;
            logic [regIndexWidth-1:0] rb;
            logic [regIndexWidth-1:0] rc;
            logic [14:0]              unused;
        } rFormat;
        struct packed {
            logic [opWidth-1:0]       op;
            logic [regIndexWidth-1:0] ra;
            logic [regIndexWidth-1:0] rb;
            logic [constWidth-1:0]    imm;  // sign extended to 32 bits
        } iFormat;
    } instrFields;

endpackage

// ==== verilog/datapathTop.sv ====
`timescale 1ns/1ps

module datapathTop (
    input  logic                             Clock,
    input  logic                             arstN,
    input  logic                             instrValid,
    output logic                             instrReady,
    input  logic [31:0]                      instrWord,
    output logic                             wbValid,
    output logic [cpuPkg::regIndexWidth-1:0] wbReg,
    output logic [31:0]                      wbData
);

    logic [cpuPkg::regIndexWidth-1:0] selRa;
    logic [cpuPkg::regIndexWidth-1:0] selRb;
    logic [cpuPkg::regIndexWidth-1:0] selRc;
    logic [31:0]                      constant;
    logic                             regIn;
    logic                             baseOut;
    logic                             rcOut;
    logic                             constOut;
    logic                             zOut;
    logic                             yLoad;
    logic                             zLoad;
    logic [cpuPkg::opWidth-1:0]       aluOp;
    logic [15:0]                      loadEn;
    logic [15:0]                      driveEn;
    logic                             baseZero;
    logic [15:0][31:0]                regValues;
    logic [31:0]                      busValue;
    logic [31:0]                      zValue;

    controlSequencer uSequencer (
        .Clock      (Clock),
        .arstN      (arstN),
        .instrValid (instrValid),
        .instrWord  (instrWord),
        .instrReady (instrReady),
        .selRa      (selRa),
        .selRb      (selRb),
        .selRc      (selRc),
        .constant   (constant),
        .regIn      (regIn),
        .baseOut    (baseOut),
        .rcOut      (rcOut),
        .constOut   (constOut),
        .zOut       (zOut),
        .yLoad      (yLoad),
        .zLoad      (zLoad),
        .aluOp      (aluOp),
        .wbValid    (wbValid),
        .wbReg      (wbReg)
    );

    registerSelect uSelect (
        .selRa    (selRa),
        .selRb    (selRb),
        .selRc    (selRc),
        .regIn    (regIn),
        .baseOut  (baseOut),
        .rcOut    (rcOut),
        .loadEn   (loadEn),
        .driveEn  (driveEn),
        .baseZero (baseZero)
    );

    for (genvar i = 0; i < 16; i++) begin : gReg
        generalRegister uReg (
            .Clock  (Clock),
            .arstN  (arstN),
            .loadEn (loadEn[i]),
            .busIn  (busValue),
            .value  (regValues[i])
        );
    end

    busMultiplexer uBus (
        .regValues (regValues),
        .driveEn   (driveEn),
        .baseZero  (baseZero),
        .constOut  (constOut),
        .constant  (constant),
        .zOut      (zOut),
        .zValue    (zValue),
        .busValue  (busValue)
    );

    aluUnit uAlu (
        .Clock    (Clock),
        .arstN    (arstN),
        .busValue (busValue),
        .yLoad    (yLoad),
        .zLoad    (zLoad),
        .aluOp    (aluOp),
        .zValue   (zValue)
    );

    assign wbData = busValue;  // Z is on the bus during write-back

endmodule

// ==== verilog/generalRegister.sv ====
`timescale 1ns/1ps

module generalRegister (
    input  logic        Clock,
    input  logic        arstN,
    input  logic        loadEn,
    input  logic [31:0] busIn,
    output logic [31:0] value
);

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            value <= '0;
        end else if (loadEn) begin
            value <= busIn;
        end
    end

endmodule

// ==== verilog/registerSelect.sv ====
`timescale 1ns/1ps

module registerSelect (
    input  logic [cpuPkg::regIndexWidth-1:0] selRa,
    input  logic [cpuPkg::regIndexWidth-1:0] selRb,
    input  logic [cpuPkg::regIndexWidth-1:0] selRc,
    input  logic                             regIn,
    input  logic                             baseOut,
    input  logic                             rcOut,
    output logic [15:0]                      loadEn,
    output logic [15:0]                      driveEn,
    output logic                             baseZero
);

    logic baseIsR0;

    assign baseIsR0 = (selRb == '0);

    always_comb begin
        loadEn = '0;
        if (regIn) begin
            loadEn[selRa] = 1'b1;  // R0 can be written like any other
        end
    end

    // R0 as base reads zero, so no register drives in that case
    always_comb begin
        driveEn = '0;
        if (baseOut && !baseIsR0) begin
            driveEn[selRb] = 1'b1;
        end
        if (rcOut) begin
            driveEn[selRc] = 1'b1;
        end
    end

    assign baseZero = baseOut && baseIsR0;

endmodule
